//--- commandParser.sv
// Rasterix command parser
`include "rasterix_settings.svh"

module commandParser import rasterixPkg::*; (
    input  logic              aclk,
    input  logic              rstN,

    // Command stream
    input  logic              cmdValid,
    input  logic              cmdLast,
    input  logic [`CMD_W-1:0] cmdData,
    output logic              cmdReady,

    // Register bank
    output logic              regWrite,
    output regIndex_t         regAddr,
    output logic [15:0]       regData,

    // Rasterizer control
    output logic              startRender,
    input  logic              rasterBusy,

    fbCtrlIf.controller       fbCtrl,
    input  logic [15:0]       clearColor,
    input  logic [15:0]       confReg
);

    localparam logic [1:0] StHeader  = 2'd0;
    localparam logic [1:0] StRegData = 2'd1;
    localparam logic [1:0] StWait    = 2'd2;

    logic [1:0] state;
    cmdWord_u   header;
    logic       accept;
    logic       memsetPulse;
    logic       commitPulse;
    logic       allIdle;

    assign header   = cmdData;
    assign cmdReady = (state != StWait);
    assign accept   = cmdValid && cmdReady;

    // Data word goes straight to the bank
    assign regWrite = accept && (state == StRegData);
    assign regData  = cmdData;

    assign fbCtrl.memset     = memsetPulse;
    assign fbCtrl.commit     = commitPulse;
    assign fbCtrl.clearColor = clearColor;
    assign fbCtrl.colorMask  = confReg[`MASK_W-1:0];

    // Pulses are still in flight on the first wait cycle
    assign allIdle = !startRender && !memsetPulse && !commitPulse
                     && !rasterBusy && !fbCtrl.fbBusy;

    ////////////////////////////////////////
    // Stream FSM
    ////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (!rstN) begin
            state       <= StHeader;
            regAddr     <= '0;
            startRender <= 1'b0;
            memsetPulse <= 1'b0;
            commitPulse <= 1'b0;
        end else begin
            startRender <= 1'b0;
            memsetPulse <= 1'b0;
            commitPulse <= 1'b0;
            case (state)
                StHeader: begin
                    if (accept) begin
                        case (header.setRegView.opcode)
                            `OP_SETREG: begin
                                regAddr <= header.setRegView.regNum;
                                state   <= StRegData;
                            end
                            `OP_FBCTRL: begin
                                // Memset wins over commit
                                memsetPulse <= header.fbCtrlView.memset;
                                commitPulse <= !header.fbCtrlView.memset
                                               && header.fbCtrlView.commit;
                                state       <= StWait;
                            end
                            `OP_RENDER: begin
                                startRender <= 1'b1;
                                state       <= StWait;
                            end
                            default: state <= StHeader;
                        endcase
                    end
                end
                StRegData: begin
                    if (accept) begin
                        state <= StHeader;
                    end
                end
                default: begin
                    if (allIdle) begin
                        state <= StHeader;
                    end
                end
            endcase
        end
    end

endmodule

//--- files.f
+incdir+.
rasterixPkg.sv
rasterixIfs.sv
commandParser.sv
registerBank.sv
rasterizer.sv
frameBuffer.sv
rasterixTop.sv
rasterix_props.sv
tbChecker.sv
tbRasterix.sv

//--- frameBuffer.sv
// Rasterix colour framebuffer
`include "rasterix_settings.svh"

module frameBuffer import rasterixPkg::*; (
    input  logic                aclk,
    input  logic                rstN,

    fragIf.sink                 frag,
    fbCtrlIf.target             fbCtrl,

    // Commit stream
    output logic                fbValid,
    output logic                fbLast,
    input  logic                fbReady,
    output logic [`PIXEL_W-1:0] fbData
);

    localparam logic [`FB_INDEX_W-1:0] LastIndex = `FB_INDEX_W'(`PIXEL_COUNT - 1);

    logic [`PIXEL_W-1:0]    mem [`PIXEL_COUNT];
    logic                   memsetActive;
    logic [`FB_INDEX_W-1:0] memsetIndex;
    logic [`FB_INDEX_W-1:0] readIndex;
    logic [`FB_INDEX_W-1:0] nextRead;
    logic                   beatAccepted;

    assign beatAccepted = fbValid && fbReady;
    assign nextRead     = fbCtrl.commit ? '0 : readIndex + 1'b1;
    assign fbCtrl.fbBusy = memsetActive || fbValid;

    // Pixel memory, memset ignores the colour mask
    always_ff @(posedge aclk) begin
        if (memsetActive) begin
            mem[memsetIndex] <= fbCtrl.clearColor;
        end else if (frag.fragWriteEnable) begin
            mem[frag.fragIndex] <= maskedMerge(mem[frag.fragIndex], frag.fragColor,
                                               fbCtrl.colorMask);
        end
    end

    ////////////////////////////////////////
    // Memset sweep
    ////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (!rstN) begin
            memsetActive <= 1'b0;
            memsetIndex  <= '0;
        end else if (fbCtrl.memset) begin
            memsetActive <= 1'b1;
            memsetIndex  <= '0;
        end else if (memsetActive) begin
            memsetIndex <= memsetIndex + 1'b1;
            if (memsetIndex == LastIndex) begin
                memsetActive <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Commit stream
    ////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (!rstN) begin
            fbValid   <= 1'b0;
            fbLast    <= 1'b0;
            readIndex <= '0;
        end else if (fbCtrl.commit) begin
            fbValid   <= 1'b1;
            fbLast    <= 1'b0;
            readIndex <= '0;
        end else if (beatAccepted) begin
            if (fbLast) begin
                fbValid <= 1'b0;
                fbLast  <= 1'b0;
            end else begin
                readIndex <= nextRead;
                fbLast    <= (nextRead == LastIndex);
            end
        end
    end

    // Output word only moves on a new beat
    always_ff @(posedge aclk) begin
        if (fbCtrl.commit || (beatAccepted && !fbLast)) begin
            fbData <= mem[nextRead];
        end
    end

endmodule

//--- rasterixIfs.sv
// Rasterix internal interfaces
`include "rasterix_settings.svh"

// Triangle setup from the register bank
interface triangleIf;
    logic [`COORD_W-1:0]       bbStartX, bbStartY, bbEndX, bbEndY;
    logic signed [`EDGE_W-1:0] w0, w1, w2;
    logic signed [`EDGE_W-1:0] w0IncX, w1IncX, w2IncX;
    logic signed [`EDGE_W-1:0] w0IncY, w1IncY, w2IncY;
    logic [`PIXEL_W-1:0]       triColor;

    modport source (output bbStartX, bbStartY, bbEndX, bbEndY, w0, w1, w2,
                    w0IncX, w1IncX, w2IncX, w0IncY, w1IncY, w2IncY, triColor);
    modport sink (input bbStartX, bbStartY, bbEndX, bbEndY, w0, w1, w2,
                  w0IncX, w1IncX, w2IncX, w0IncY, w1IncY, w2IncY, triColor);
endinterface

// Fragment write strobe, no handshake
interface fragIf;
    logic                    fragWriteEnable;
    logic [`FB_INDEX_W-1:0]  fragIndex;
    logic [`PIXEL_W-1:0]     fragColor;

    modport source (output fragWriteEnable, fragIndex, fragColor);
    modport sink (input fragWriteEnable, fragIndex, fragColor);
endinterface

// Framebuffer operation control
interface fbCtrlIf;
    logic                memset;
    logic                commit;
    logic [`PIXEL_W-1:0] clearColor;
    logic [`MASK_W-1:0]  colorMask;
    logic                fbBusy;

    modport controller (output memset, commit, clearColor, colorMask, input fbBusy);
    modport target (input memset, commit, clearColor, colorMask, output fbBusy);
endinterface

//--- rasterixPkg.sv
// Rasterix shared types
`include "rasterix_settings.svh"

package rasterixPkg;

    typedef logic [3:0] regIndex_t;

    // One header word, decoded per opcode
    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            regIndex_t  regNum;
            logic [7:0] unused;
        } setRegView;
        struct packed {
            logic [3:0] opcode;
            logic       memset;
            logic       commit;
            logic [9:0] unused;
        } fbCtrlView;
    } cmdWord_u;

    // Linear framebuffer address of a screen pixel
    function automatic logic [`FB_INDEX_W-1:0] pixelIndex(input logic [`COORD_W-1:0] x,
                                                          input logic [`COORD_W-1:0] y);
        return `FB_INDEX_W'(y * `SCREEN_W + x);
    endfunction

    // Replace only the nibbles enabled in mask, bit 3 is the top nibble
    function automatic logic [`PIXEL_W-1:0] maskedMerge(input logic [`PIXEL_W-1:0] oldPix,
                                                        input logic [`PIXEL_W-1:0] newPix,
                                                        input logic [`MASK_W-1:0] mask);
        logic [`PIXEL_W-1:0] result;
        result = oldPix;
        for (int i = 0; i < `MASK_W; i++) begin
            if (mask[i]) begin
                result[i*4 +: 4] = newPix[i*4 +: 4];
            end
        end
        return result;
    endfunction

endpackage

//--- rasterixTop.sv
// Rasterix top level
`include "rasterix_settings.svh"

module rasterixTop import rasterixPkg::*; (
    input  logic                aclk,
    input  logic                rstN,

    // Command stream in
    input  logic                cmdValid,
    output logic                cmdReady,
    input  logic                cmdLast,
    input  logic [`CMD_W-1:0]   cmdData,

    // Framebuffer stream out
    output logic                fbValid,
    input  logic                fbReady,
    output logic                fbLast,
    output logic [`PIXEL_W-1:0] fbData
);

    logic        regWrite;
    regIndex_t   regAddr;
    logic [15:0] regData;
    logic        startRender;
    logic        rasterBusy;
    logic [15:0] clearColor;
    logic [15:0] confReg;

    triangleIf triBus ();
    fragIf     fragBus ();
    fbCtrlIf   fbCtrlBus ();

    commandParser parser (
        .aclk        (aclk),
        .rstN        (rstN),
        .cmdValid    (cmdValid),
        .cmdLast     (cmdLast),
        .cmdData     (cmdData),
        .cmdReady    (cmdReady),
        .regWrite    (regWrite),
        .regAddr     (regAddr),
        .regData     (regData),
        .startRender (startRender),
        .rasterBusy  (rasterBusy),
        .fbCtrl      (fbCtrlBus.controller),
        .clearColor  (clearColor),
        .confReg     (confReg)
    );

    registerBank regBank (
        .aclk       (aclk),
        .rstN       (rstN),
        .regWrite   (regWrite),
        .regAddr    (regAddr),
        .regData    (regData),
        .triangle   (triBus.source),
        .clearColor (clearColor),
        .confReg    (confReg)
    );

    rasterizer raster (
        .aclk        (aclk),
        .rstN        (rstN),
        .startRender (startRender),
        .rasterBusy  (rasterBusy),
        .triangle    (triBus.sink),
        .frag        (fragBus.source)
    );

    frameBuffer colorBuffer (
        .aclk    (aclk),
        .rstN    (rstN),
        .frag    (fragBus.sink),
        .fbCtrl  (fbCtrlBus.target),
        .fbValid (fbValid),
        .fbLast  (fbLast),
        .fbReady (fbReady),
        .fbData  (fbData)
    );

endmodule

//--- rasterix_props.sv
// Rasterix handshake properties
`include "rasterix_settings.svh"

module rasterixProps (
    input logic                aclk,
    input logic                rstN,
    input logic                cmdReady,
    input logic                rasterBusy,
    input logic                fbBusy,
    input logic                fbValid,
    input logic                fbReady,
    input logic                fbLast,
    input logic [`PIXEL_W-1:0] fbData
);

    // Output beat held under back-pressure
    holdWhileStalled: assert property (@(posedge aclk) disable iff (!rstN)
        (fbValid && !fbReady) |=> (fbValid && $stable(fbData) && $stable(fbLast)))
        else $error("framebuffer stream changed while stalled");

    lastNeedsValid: assert property (@(posedge aclk) disable iff (!rstN)
        fbLast |-> fbValid)
        else $error("fbLast raised without fbValid");

    // No new command while a long operation runs
    stallWhileBusy: assert property (@(posedge aclk) disable iff (!rstN)
        (rasterBusy || fbBusy) |-> !cmdReady)
        else $error("cmdReady high while an operation is busy");

endmodule

bind rasterixTop rasterixProps streamProps (
    .aclk       (aclk),
    .rstN       (rstN),
    .cmdReady   (cmdReady),
    .rasterBusy (rasterBusy),
    .fbBusy     (fbCtrlBus.fbBusy),
    .fbValid    (fbValid),
    .fbReady    (fbReady),
    .fbLast     (fbLast),
    .fbData     (fbData)
);

//--- rasterix_settings.svh
// Rasterix build constants
`ifndef RASTERIX_SETTINGS_SVH
`define RASTERIX_SETTINGS_SVH

// Screen geometry
`define SCREEN_W 16
`define SCREEN_H 16
`define PIXEL_COUNT 256
`define FB_INDEX_W 8

// Datapath widths
`define CMD_W 16
`define PIXEL_W 16
`define COORD_W 8
`define EDGE_W 16
`define MASK_W 4

// Command opcodes
`define OP_SETREG 1
`define OP_FBCTRL 2
`define OP_RENDER 3

////////////////////////////////////////
// Register addresses
////////////////////////////////////////
`define REG_BB_START 0
`define REG_BB_END 1
`define REG_W0 2
`define REG_W1 3
`define REG_W2 4
`define REG_W0_INC_X 5
`define REG_W1_INC_X 6
`define REG_W2_INC_X 7
`define REG_W0_INC_Y 8
`define REG_W1_INC_Y 9
`define REG_W2_INC_Y 10
`define REG_TRI_COLOR 11
`define REG_CLEAR_COLOR 12
`define REG_CONF 13

`endif

//--- rasterizer.sv
// Rasterix edge function rasterizer
`include "rasterix_settings.svh"

module rasterizer import rasterixPkg::*; (
    input  logic     aclk,
    input  logic     rstN,

    input  logic     startRender,
    output logic     rasterBusy,

    triangleIf.sink  triangle,
    fragIf.source    frag
);

    logic [`COORD_W-1:0]       x;
    logic [`COORD_W-1:0]       y;
    logic signed [`EDGE_W-1:0] wInit [3];
    logic signed [`EDGE_W-1:0] incX [3];
    logic signed [`EDGE_W-1:0] incY [3];
    logic signed [`EDGE_W-1:0] edgeVal [3];
    logic signed [`EDGE_W-1:0] rowVal [3];
    logic                      rowEnd;
    logic                      covered;

    assign wInit[0] = triangle.w0;
    assign wInit[1] = triangle.w1;
    assign wInit[2] = triangle.w2;
    assign incX[0]  = triangle.w0IncX;
    assign incX[1]  = triangle.w1IncX;
    assign incX[2]  = triangle.w2IncX;
    assign incY[0]  = triangle.w0IncY;
    assign incY[1]  = triangle.w1IncY;
    assign incY[2]  = triangle.w2IncY;

    assign rowEnd  = (x == triangle.bbEndX);
    assign covered = (edgeVal[0] >= 0) && (edgeVal[1] >= 0) && (edgeVal[2] >= 0);

    // Pixel is written in the cycle it is visited
    assign frag.fragWriteEnable = rasterBusy && covered;
    assign frag.fragIndex       = pixelIndex(x, y);
    assign frag.fragColor       = triangle.triColor;

    ////////////////////////////////////////
    // Bounding box walk
    ////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (!rstN) begin
            rasterBusy <= 1'b0;
            x          <= '0;
            y          <= '0;
        end else if (startRender) begin
            rasterBusy <= 1'b1;
            x          <= triangle.bbStartX;
            y          <= triangle.bbStartY;
        end else if (rasterBusy) begin
            if (rowEnd) begin
                x <= triangle.bbStartX;
                if (y == triangle.bbEndY) begin
                    rasterBusy <= 1'b0;
                end else begin
                    y <= y + 1'b1;
                end
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // Edge values step by X along a row and by Y from the row start
    always_ff @(posedge aclk) begin
        for (int k = 0; k < 3; k++) begin
            if (startRender) begin
                edgeVal[k] <= wInit[k];
                rowVal[k]  <= wInit[k];
            end else if (rasterBusy && rowEnd) begin
                edgeVal[k] <= rowVal[k] + incY[k];
                rowVal[k]  <= rowVal[k] + incY[k];
            end else if (rasterBusy) begin
                edgeVal[k] <= edgeVal[k] + incX[k];
            end
        end
    end

endmodule

//--- registerBank.sv
// Rasterix triangle register bank
`include "rasterix_settings.svh"

module registerBank import rasterixPkg::*; (
    input  logic        aclk,
    input  logic        rstN,

    input  logic        regWrite,
    input  regIndex_t   regAddr,
    input  logic [15:0] regData,

    triangleIf.source   triangle,
    output logic [15:0] clearColor,
    output logic [15:0] confReg
);

    localparam int RegCount = `REG_CONF + 1;

    logic [15:0] regs [RegCount];

    always_ff @(posedge aclk) begin
        if (!rstN) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
            // All nibbles writable by default
            regs[`REG_CONF] <= 16'h000f;
        end else if (regWrite && (regAddr < RegCount)) begin
            regs[regAddr] <= regData;
        end
    end

    ////////////////////////////////////////
    // Triangle view
    ////////////////////////////////////////
    // X in the high byte, Y in the low byte
    assign triangle.bbStartX = regs[`REG_BB_START][15:8];
    assign triangle.bbStartY = regs[`REG_BB_START][7:0];
    assign triangle.bbEndX   = regs[`REG_BB_END][15:8];
    assign triangle.bbEndY   = regs[`REG_BB_END][7:0];

    assign triangle.w0     = $signed(regs[`REG_W0]);
    assign triangle.w1     = $signed(regs[`REG_W1]);
    assign triangle.w2     = $signed(regs[`REG_W2]);
    assign triangle.w0IncX = $signed(regs[`REG_W0_INC_X]);
    assign triangle.w1IncX = $signed(regs[`REG_W1_INC_X]);
    assign triangle.w2IncX = $signed(regs[`REG_W2_INC_X]);
    assign triangle.w0IncY = $signed(regs[`REG_W0_INC_Y]);
    assign triangle.w1IncY = $signed(regs[`REG_W1_INC_Y]);
    assign triangle.w2IncY = $signed(regs[`REG_W2_INC_Y]);

    assign triangle.triColor = regs[`REG_TRI_COLOR];

    assign clearColor = regs[`REG_CLEAR_COLOR];
    assign confReg    = regs[`REG_CONF];

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tbRasterix -o simRasterix
./obj_dir/simRasterix > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
    echo "Simulation stopped without a result"
    exit 1
fi
echo "Simulation passed"

//--- tbChecker.sv
// Framebuffer stream checker
`include "rasterix_settings.svh"

module tbChecker (
    input  logic                aclk,
    input  logic                rstN,
    input  logic                fbValid,
    input  logic                fbReady,
    input  logic                fbLast,
    input  logic [`PIXEL_W-1:0] fbData,
    input  logic [`PIXEL_W-1:0] expected [`PIXEL_COUNT],
    input  int                  testNum,
    output int                  framesSeen,
    output int                  errorCount,
    output int                  failedTests
);

    int   beatIndex;
    int   frameErrors;
    logic lastExpected;

    // Compare every accepted beat against the model frame
    always @(posedge aclk) begin
        if (!rstN) begin
            beatIndex   = 0;
            frameErrors = 0;
            framesSeen  <= 0;
            errorCount  <= 0;
            failedTests <= 0;
        end else if (fbValid && fbReady) begin
            lastExpected = (beatIndex == `PIXEL_COUNT - 1);
            if (fbData !== expected[beatIndex]) begin
                $display("error at %0t: test %0d pixel (%0d,%0d) is %h, expected %h",
                         $time, testNum, beatIndex % `SCREEN_W, beatIndex / `SCREEN_W,
                         fbData, expected[beatIndex]);
                frameErrors++;
            end
            if (fbLast !== lastExpected) begin
                $display("error at %0t: test %0d fbLast is %b on beat %0d",
                         $time, testNum, fbLast, beatIndex);
                frameErrors++;
            end
            // Frame ends after 256 beats
            if (lastExpected) begin
                if (frameErrors == 0) begin
                    $display("test %0d passed, %0d pixels checked", testNum, `PIXEL_COUNT);
                end else begin
                    $display("test %0d failed with %0d errors", testNum, frameErrors);
                    failedTests <= failedTests + 1;
                end
                errorCount  <= errorCount + frameErrors;
                framesSeen  <= framesSeen + 1;
                beatIndex   = 0;
                frameErrors = 0;
            end else begin
                beatIndex++;
            end
        end
    end

endmodule

//--- tbRasterix.sv
// Rasterix testbench
`include "rasterix_settings.svh"

module tbRasterix;

    typedef struct packed {
        logic [7:0]         startX;
        logic [7:0]         startY;
        logic [7:0]         endX;
        logic [7:0]         endY;
        logic signed [15:0] w0, w1, w2;
        logic signed [15:0] w0IncX, w1IncX, w2IncX;
        logic signed [15:0] w0IncY, w1IncY, w2IncY;
        logic [15:0]        triColor;
        logic [15:0]        clearColor;
        logic [3:0]         mask;
        logic               doMemset;
    } testCase_t;

    localparam int RowCount  = 6;
    localparam int WaitLimit = 2000;

    logic                aclk;
    logic                rstN;
    logic                cmdValid;
    logic                cmdReady;
    logic                cmdLast;
    logic [`CMD_W-1:0]   cmdData;
    logic                fbValid;
    logic                fbReady;
    logic                fbLast;
    logic [`PIXEL_W-1:0] fbData;

    logic [`PIXEL_W-1:0] modelFb [`PIXEL_COUNT];
    testCase_t           testTable [RowCount];
    logic [31:0]         lfsrState;
    logic                timedOut;
    int                  testNum;
    int                  framesSeen;
    int                  errorCount;
    int                  failedTests;

    rasterixTop UUT (
        .aclk     (aclk),
        .rstN     (rstN),
        .cmdValid (cmdValid),
        .cmdReady (cmdReady),
        .cmdLast  (cmdLast),
        .cmdData  (cmdData),
        .fbValid  (fbValid),
        .fbReady  (fbReady),
        .fbLast   (fbLast),
        .fbData   (fbData)
    );

    tbChecker frameCheck (
        .aclk        (aclk),
        .rstN        (rstN),
        .fbValid     (fbValid),
        .fbReady     (fbReady),
        .fbLast      (fbLast),
        .fbData      (fbData),
        .expected    (modelFb),
        .testNum     (testNum),
        .framesSeen  (framesSeen),
        .errorCount  (errorCount),
        .failedTests (failedTests)
    );

    initial aclk = 1'b0;
    always #10 aclk = ~aclk;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic signed [15:0] edgeAt(input logic signed [15:0] w, incX, incY,
                                                  input logic signed [15:0] dx, dy);
        return w + dx * incX + dy * incY;
    endfunction

    function automatic logic [15:0] mergeNibbles(input logic [15:0] oldPix, newPix,
                                                 input logic [`MASK_W-1:0] mask);
        logic [15:0] keepNew;
        keepNew = {{4{mask[3]}}, {4{mask[2]}}, {4{mask[1]}}, {4{mask[0]}}};
        return (newPix & keepNew) | (oldPix & ~keepNew);
    endfunction

    function automatic logic [15:0] regValue(input testCase_t tc, input int idx);
        case (idx)
            `REG_BB_START:    return {tc.startX, tc.startY};
            `REG_BB_END:      return {tc.endX, tc.endY};
            `REG_W0:          return tc.w0;
            `REG_W1:          return tc.w1;
            `REG_W2:          return tc.w2;
            `REG_W0_INC_X:    return tc.w0IncX;
            `REG_W1_INC_X:    return tc.w1IncX;
            `REG_W2_INC_X:    return tc.w2IncX;
            `REG_W0_INC_Y:    return tc.w0IncY;
            `REG_W1_INC_Y:    return tc.w1IncY;
            `REG_W2_INC_Y:    return tc.w2IncY;
            `REG_TRI_COLOR:   return tc.triColor;
            `REG_CLEAR_COLOR: return tc.clearColor;
            default:          return {12'h000, tc.mask};
        endcase
    endfunction

    // Expected frame after optional clear and one triangle
    task automatic renderModel(input testCase_t tc);
        logic signed [15:0] dx;
        logic signed [15:0] dy;
        int                 idx;
        if (tc.doMemset) begin
            for (int i = 0; i < `PIXEL_COUNT; i++) begin
                modelFb[i] = tc.clearColor;
            end
        end
        for (int y = int'(tc.startY); y <= int'(tc.endY); y++) begin
            for (int x = int'(tc.startX); x <= int'(tc.endX); x++) begin
                dx = 16'(x - int'(tc.startX));
                dy = 16'(y - int'(tc.startY));
                if (edgeAt(tc.w0, tc.w0IncX, tc.w0IncY, dx, dy) >= 0
                    && edgeAt(tc.w1, tc.w1IncX, tc.w1IncY, dx, dy) >= 0
                    && edgeAt(tc.w2, tc.w2IncX, tc.w2IncY, dx, dy) >= 0) begin
                    idx = y * `SCREEN_W + x;
                    modelFb[idx] = mergeNibbles(modelFb[idx], tc.triColor, tc.mask);
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // Stream drivers
    ////////////////////////////////////////
    // Called 2 units after a rising edge, returns at the same phase
    task automatic sendWord(input logic [`CMD_W-1:0] word);
        int waited;
        waited = 0;
        if (!timedOut) begin
            cmdValid = 1'b1;
            cmdData  = word;
            while (!cmdReady && waited < WaitLimit) begin
                @(posedge aclk);
                #2;
                waited++;
            end
            if (cmdReady) begin
                @(posedge aclk);
                #2;
            end else begin
                $display("timeout: command word %h was never accepted", word);
                timedOut = 1'b1;
            end
            cmdValid = 1'b0;
        end
    endtask

    task automatic commitFrame(input int frameTarget);
        int waited;
        waited = 0;
        sendWord({4'(`OP_FBCTRL), 1'b0, 1'b1, 10'd0});
        // Random back-pressure, one LFSR bit per cycle
        while (!timedOut && framesSeen < frameTarget && waited < WaitLimit) begin
            lfsrState = lfsrStep(lfsrState);
            fbReady   = lfsrState[0];
            @(posedge aclk);
            #2;
            waited++;
        end
        fbReady = 1'b0;
        if (!timedOut && framesSeen < frameTarget) begin
            $display("timeout: frame of test %0d did not finish streaming", testNum);
            timedOut = 1'b1;
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        rstN      = 1'b0;
        cmdValid  = 1'b0;
        cmdLast   = 1'b0;
        cmdData   = '0;
        fbReady   = 1'b0;
        timedOut  = 1'b0;
        testNum   = 0;
        lfsrState = 32'he73b;

        // Box, edges, X increments, Y increments, colours, mask, memset
        testTable[0] = '{8'd0, 8'd0, 8'd0, 8'd0, -16'sd1, 16'sd0, 16'sd0,
                         16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0,
                         16'hffff, 16'h1234, 4'hf, 1'b1};
        testTable[1] = '{8'd2, 8'd3, 8'd9, 8'd12, 16'sd1, 16'sd1, 16'sd1,
                         16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0,
                         16'hf81f, 16'h0000, 4'hf, 1'b1};
        testTable[2] = '{8'd0, 8'd0, 8'd15, 8'd15, 16'sd0, 16'sd20, 16'sd0,
                         16'sd1, -16'sd1, 16'sd0, -16'sd1, -16'sd1, 16'sd1,
                         16'h07e0, 16'h5555, 4'hf, 1'b1};
        testTable[3] = '{8'd4, 8'd4, 8'd11, 8'd11, 16'sd5, 16'sd5, 16'sd5,
                         16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0,
                         16'habcd, 16'h1111, 4'b1010, 1'b1};
        // No clear from here on
        testTable[4] = '{8'd0, 8'd0, 8'd7, 8'd7, 16'sd7, 16'sd0, 16'sd0,
                         -16'sd1, 16'sd0, 16'sd0, -16'sd1, 16'sd0, 16'sd0,
                         16'h00ff, 16'h0000, 4'hf, 1'b0};
        testTable[5] = '{8'd8, 8'd0, 8'd15, 8'd15, -16'sd3, 16'sd0, 16'sd30,
                         16'sd1, 16'sd0, -16'sd1, 16'sd0, 16'sd1, -16'sd2,
                         16'h9999, 16'h0000, 4'b0101, 1'b0};

        repeat (8) @(posedge aclk);
        #2;
        rstN = 1'b1;

        for (int r = 0; r < RowCount && !timedOut; r++) begin
            testNum = r;
            for (int i = 0; i <= `REG_CONF; i++) begin
                sendWord({4'(`OP_SETREG), 4'(i), 8'h00});
                sendWord(regValue(testTable[r], i));
            end
            if (testTable[r].doMemset) begin
                sendWord({4'(`OP_FBCTRL), 1'b1, 1'b0, 10'd0});
            end
            sendWord({4'(`OP_RENDER), 12'h000});
            renderModel(testTable[r]);
            commitFrame(r + 1);
        end

        $display("%0d tests run, %0d failed, %0d errors", framesSeen, failedTests, errorCount);
        if (timedOut || errorCount != 0 || failedTests != 0 || framesSeen != RowCount) begin
            $display("TB FAILED");
        end else begin
            $display("TB PASSED");
        end
        $finish;
    end

endmodule
